/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_qupls_fpu32
FILELIST = src.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* change_det.sv */
`default_nettype none

module change_det (
	input wire logic rst,
	input wire logic clk,
	input wire logic [63:0] d,
	output logic cd
);

	// Operand pair seen at the last clock edge
	logic [63:0] prev;

	// Load every cycle, so cd lasts exactly one cycle per change
	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			prev <= '0;
		else
			prev <= d;
	end

	// Combinational flag, high in the cycle the new pair first appears
	assign cd = (d != prev);

endmodule

`default_nettype wire

/* f2i32.sv */
`default_nettype none

module f2i32 (
	input wire logic rst,
	input wire logic clk,
	input wire fp32_pkg::fp32_t a,
	output qupls_pkg::word_t o
);
	import fp32_pkg::*;
	import qupls_pkg::*;

	logic sgn;
	exp8_t expo;
	man23_t man;
	word_t mag;
	word_t res;

	always_comb begin
		sgn = a[31];
		expo = a[30:23];
		man = a[22:0];
		mag = '0;
		if (expo == 8'hFF && man != '0) begin
			// NaN has no sign worth keeping
			res = INT32_MAX;
		end else if (expo < FP32_BIAS) begin
			// Magnitude below one truncates to zero
			res = '0;
		end else if (expo >= FP32_BIAS + 8'd31) begin
			// Out of range and infinities clamp.
			// The negative side clamps to the most negative integer
			res = sgn ? ~INT32_MAX : INT32_MAX;
		end else begin
			// Binary point of the significand sits at bit 23
			if (expo >= FP32_BIAS + 8'd23)
				mag = {8'h00, 1'b1, man} << (expo - (FP32_BIAS + 8'd23));
			else
				mag = {8'h00, 1'b1, man} >> ((FP32_BIAS + 8'd23) - expo);
			res = sgn ? -mag : mag;
		end
	end

	// Result register, loaded every cycle
	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			o <= '0;
		else
			o <= res;
	end

endmodule

`default_nettype wire

/* fp32_pkg.sv */
`default_nettype none

package fp32_pkg;

	// Storage formats
	typedef logic [31:0] fp32_t;
	typedef logic [15:0] fp16_t;

	// Single precision fields
	typedef logic [7:0] exp8_t;
	typedef logic [22:0] man23_t;

	// Exponent biases of the two formats
	localparam exp8_t FP32_BIAS = 8'd127;
	localparam logic [4:0] FP16_BIAS = 5'd15;

	// Constants used by the sign function and the integer conversion
	localparam fp32_t FP32_ONE = 32'h3F80_0000;
	localparam fp32_t FP32_QNAN = 32'h7FC0_0000;
	localparam logic [31:0] INT32_MAX = 32'h7FFF_FFFF;

endpackage

`default_nettype wire

/* fp_cvt16to32.sv */
`default_nettype none

module fp_cvt16to32 (
	input wire fp32_pkg::fp16_t a,
	output fp32_pkg::fp32_t o
);
	import fp32_pkg::*;

	logic sgn;
	logic [4:0] e16;
	logic [9:0] f16;
	logic [3:0] msb;
	logic [9:0] fnorm;
	exp8_t expo;
	man23_t frac;

	always_comb begin
		sgn = a[15];
		e16 = a[14:10];
		f16 = a[9:0];

		// Leading one of the fraction, needed for subnormals only
		msb = '0;
		for (int k = 0; k < 10; k++) begin
			if (f16[k])
				msb = k[3:0];
		end
		fnorm = f16 << (4'd10 - msb);

		if (e16 == 5'h1F) begin
			// Infinity and NaN keep their fraction payload
			expo = 8'hFF;
			frac = {f16, 13'd0};
		end else if (e16 == '0 && f16 == '0) begin
			expo = '0;
			frac = '0;
		end else if (e16 == '0) begin
			// Subnormal value is f16 times 2^-24
			expo = FP32_BIAS - {3'b000, FP16_BIAS} - 8'd9 + {4'b0000, msb};
			frac = {fnorm, 13'd0};
		end else begin
			expo = {3'b000, e16} + FP32_BIAS - {3'b000, FP16_BIAS};
			frac = {f16, 13'd0};
		end
		o = {sgn, expo, frac};
	end

endmodule

`default_nettype wire

/* fp_trunc32.sv */
`default_nettype none

module fp_trunc32 (
	input wire logic rst,
	input wire logic clk,
	input wire fp32_pkg::fp32_t a,
	output fp32_pkg::fp32_t o
);
	import fp32_pkg::*;

	exp8_t expo;
	man23_t mask;
	fp32_t res;

	always_comb begin
		expo = a[30:23];
		mask = '1;
		if (expo < FP32_BIAS) begin
			// Pure fraction, keep only the sign
			res = {a[31], 31'd0};
		end else if (expo >= FP32_BIAS + 8'd23) begin
			// Already integral, also covers infinity and NaN
			res = a;
		end else begin
			// Drop the fraction bits that lie below the binary point
			mask = 23'h7F_FFFF << ((FP32_BIAS + 8'd23) - expo);
			res = {a[31:23], a[22:0] & mask};
		end
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			o <= '0;
		else
			o <= res;
	end

endmodule

`default_nettype wire

/* i2f32.sv */
`default_nettype none

module i2f32 (
	input wire logic rst,
	input wire logic clk,
	input wire qupls_pkg::word_t a,
	output fp32_pkg::fp32_t o
);
	import fp32_pkg::*;
	import qupls_pkg::*;

	logic sgn;
	word_t mag;
	word_t norm;
	logic [4:0] msb;
	exp8_t expo;
	logic lsb;
	logic guard;
	logic sticky;
	logic rnd;
	fp32_t res;

	always_comb begin
		sgn = a[31];
		// The most negative integer stays 0x80000000, read as unsigned
		mag = sgn ? -a : a;

		// Leading one search, the highest set bit wins
		msb = '0;
		for (int k = 0; k < 32; k++) begin
			if (mag[k])
				msb = k[4:0];
		end

		// Move the leading one to bit 31, it becomes the hidden bit
		norm = mag << (5'd31 - msb);
		expo = FP32_BIAS + {3'b000, msb};

		// Round to nearest, ties to even
		lsb = norm[8];
		guard = norm[7];
		sticky = |norm[6:0];
		rnd = guard & (sticky | lsb);

		if (mag == '0)
			res = '0;
		else
			// A carry out of the fraction bumps the exponent as it should
			res = {sgn, expo, norm[30:8]} + {31'd0, rnd};
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			o <= '0;
		else
			o <= res;
	end

endmodule

`default_nettype wire

/* qupls_cmp.sv */
`default_nettype none

module qupls_cmp (
	input wire qupls_pkg::instr_t ir,
	input wire qupls_pkg::word_t a,
	input wire qupls_pkg::word_t b,
	input wire qupls_pkg::word_t i,
	output qupls_pkg::word_t cmpo
);
	import qupls_pkg::*;
	import fp32_pkg::*;

	opcode_t opcode;
	word_t rhs;
	logic unsgn;
	logic eq;
	logic lt;
	logic unord;
	logic nan_a;
	logic nan_b;
	fp32_t fa;
	fp32_t fb;
	word_t ka;
	word_t kb;

	always_comb begin
		opcode = ir[OPC_MSB:OPC_LSB];
		// Immediate compares take i in place of b
		rhs = (opcode == OP_CMPI || opcode == OP_CMPUI) ? i : b;
		unsgn = (opcode == OP_CMPUI) ||
			(opcode == OP_R3 && ir[FN_MSB:FN_LSB] == FN_CMPU);

		// Fold negative zero onto positive zero before building the keys
		fa = (a[30:0] == '0) ? '0 : a;
		fb = (b[30:0] == '0) ? '0 : b;
		// Sign-magnitude mapped onto an unsigned ordering.
		// Negatives are inverted, positives get the top bit set
		ka = fa[31] ? ~fa : {1'b1, fa[30:0]};
		kb = fb[31] ? ~fb : {1'b1, fb[30:0]};
		nan_a = (&a[30:23]) && (|a[22:0]);
		nan_b = (&b[30:23]) && (|b[22:0]);

		unord = 1'b0;
		if (opcode == OP_FLT3) begin
			// Any NaN leaves the pair unordered and every relation false
			unord = nan_a | nan_b;
			eq = ~unord & (ka == kb);
			lt = ~unord & (ka < kb);
		end else begin
			eq = (a == rhs);
			lt = unsgn ? (a < rhs) : ($signed(a) < $signed(rhs));
		end

		// Bit 4 gt, bit 3 unordered, bit 2 le, bit 1 lt, bit 0 eq
		cmpo = {27'd0, ~unord & ~eq & ~lt, unord, eq | lt, lt, eq};
	end

endmodule

`default_nettype wire

/* qupls_fpu32.sv */
`default_nettype none

module qupls_fpu32 (
	input wire logic rst,
	input wire logic clk,
	input wire qupls_pkg::instr_t ir,
	input wire qupls_pkg::word_t a,
	input wire qupls_pkg::word_t b,
	input wire qupls_pkg::word_t c,
	input wire qupls_pkg::word_t i,
	output qupls_pkg::word_t o,
	output logic done
);
	import qupls_pkg::*;
	import fp32_pkg::*;

	logic cd;
	cnt_t cnt;
	word_t cmpo;
	word_t f2io;
	fp32_t i2fo;
	fp32_t trunco;
	fp32_t cvto;
	opcode_t opcode;
	func_t func;
	func_t fn1;
	op4_t op4;
	word_t base;
	word_t combo;

	// =========================================================================
	// Operation cores
	// =========================================================================

	// New operands are the only sign that a new operation was issued
	change_det u_arg_cd (
		.rst(rst),
		.clk(clk),
		.d({a, b}),
		.cd(cd)
	);

	qupls_cmp u_cmp (
		.ir(ir),
		.a(a),
		.b(b),
		.i(i),
		.cmpo(cmpo)
	);

	f2i32 u_f2i (
		.rst(rst),
		.clk(clk),
		.a(a),
		.o(f2io)
	);

	i2f32 u_i2f (
		.rst(rst),
		.clk(clk),
		.a(a),
		.o(i2fo)
	);

	fp_trunc32 u_trunc (
		.rst(rst),
		.clk(clk),
		.a(a),
		.o(trunco)
	);

	// Half precision source sits in the low half of a
	fp_cvt16to32 u_cvt (
		.a(a[15:0]),
		.o(cvto)
	);

	// Restarts on an operand change, then counts and holds at 15
	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			cnt <= '0;
		else if (cd)
			cnt <= '0;
		else if (cnt != 4'hF)
			cnt <= cnt + 4'd1;
	end

	// =========================================================================
	// Decode, result select and done
	// =========================================================================
	always_comb begin
		opcode = ir[OPC_MSB:OPC_LSB];
		func = ir[FN_MSB:FN_LSB];
		fn1 = ir[FN1_MSB:FN1_LSB];
		op4 = ir[OP4_MSB:OP4_LSB];
		o = '0;
		done = 1'b1;

		// First stage of the three-operand integer functions
		case (func)
			FN_ADD: base = a + b;
			FN_SUB: base = a - b;
			FN_AND: base = a & b;
			FN_OR: base = a | b;
			FN_EOR: base = a ^ b;
			FN_NAND: base = ~(a & b);
			FN_NOR: base = ~(a | b);
			FN_ENOR: base = ~(a ^ b);
			default: base = '0;
		endcase

		// Second stage folds in c, code 7 replaces both stages
		case (op4)
			3'd0: combo = base & c;
			3'd1: combo = base | c;
			3'd2: combo = base ^ c;
			3'd3: combo = base + c;
			3'd7: begin
				if (func == FN_OR)
					combo = (a & b) | (a & c) | (b & c);
				else if (func == FN_EOR)
					combo = {31'd0, (^a) ^ (^b) ^ (^c)};
				else
					combo = '0;
			end
			default: combo = '0;
		endcase

		case (opcode)
			OP_R3: begin
				case (func)
					FN_ADD, FN_SUB, FN_AND, FN_OR, FN_EOR, FN_NAND, FN_NOR, FN_ENOR:
						o = combo;
					FN_CMP, FN_CMPU: o = cmpo;
					FN_CMOVZ: o = (a != '0) ? c : b;
					FN_CMOVNZ: o = (a != '0) ? b : c;
					FN_MVVR: o = a;
					default: o = '0;
				endcase
			end
			OP_FLT3: begin
				case (func)
					FN_FLT1: begin
						case (fn1)
							FN_FABS: o = {1'b0, a[30:0]};
							FN_FNEG: o = {~a[31], a[30:0]};
							FN_FSIGN: begin
								// NaN gives a quiet NaN, zero keeps its own sign
								if ((&a[30:23]) && (|a[22:0]))
									o = FP32_QNAN;
								else if (a[30:0] == '0)
									o = a;
								else
									o = {a[31], FP32_ONE[30:0]};
							end
							FN_ISNAN: o = {31'd0, (&a[30:23]) && (|a[22:0])};
							FN_FINITE: o = {31'd0, ~&a[30:23]};
							FN_FCVTH2S: o = cvto;
							// Registered cores are ready once the counter
							// reaches their latency after the last change
							FN_FTOI: begin
								o = f2io;
								done = ~cd & (cnt >= LAT_FTOI);
							end
							FN_ITOF: begin
								o = i2fo;
								done = ~cd & (cnt >= LAT_ITOF);
							end
							FN_FTRUNC: begin
								o = trunco;
								done = ~cd & (cnt >= LAT_FTRUNC);
							end
							default: o = '0;
						endcase
					end
					FN_FSEQ: o = {31'd0, cmpo[0]};
					FN_FSNE: o = {31'd0, ~cmpo[0]};
					FN_FSLT: o = {31'd0, cmpo[1]};
					FN_FSLE: o = {31'd0, cmpo[2]};
					FN_FCMP: o = cmpo;
					// Sign from a, magnitude from b
					FN_SGNJ: o = {a[31], b[30:0]};
					FN_SGNJN: o = {~a[31], b[30:0]};
					FN_SGNJX: o = {a[31] ^ b[31], b[30:0]};
					default: o = '0;
				endcase
			end
			OP_ADDI: o = a + i;
			OP_CMPI, OP_CMPUI: o = cmpo;
			OP_ANDI: o = a & i;
			OP_ORI: o = a | i;
			OP_EORI: o = a ^ i;
			OP_MOV: o = a;
			OP_NOP: o = '0;
			default: o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* qupls_pkg.sv */
`default_nettype none

package qupls_pkg;

	// =========================================================================
	// Instruction word and its fields
	// =========================================================================
	typedef logic [31:0] instr_t;
	typedef logic [6:0] opcode_t;
	typedef logic [6:0] func_t;
	typedef logic [2:0] op4_t;

	// Data word and the cycle counter of the multi-cycle operations
	typedef logic [31:0] word_t;
	typedef logic [3:0] cnt_t;

	// Major opcode sits in the low seven bits of every format
	localparam int OPC_LSB = 0;
	localparam int OPC_MSB = 6;
	// Three-operand function and float function share the top seven bits
	localparam int FN_LSB = 25;
	localparam int FN_MSB = 31;
	// Float sub-function, only meaningful when the float function is FN_FLT1
	localparam int FN1_LSB = 16;
	localparam int FN1_MSB = 22;
	// Combine field of the three-operand integer format
	localparam int OP4_LSB = 22;
	localparam int OP4_MSB = 24;

	localparam opcode_t OP_R3 = 7'h02;
	localparam opcode_t OP_ADDI = 7'h04;
	localparam opcode_t OP_ANDI = 7'h08;
	localparam opcode_t OP_ORI = 7'h09;
	localparam opcode_t OP_EORI = 7'h0A;
	localparam opcode_t OP_CMPI = 7'h0B;
	localparam opcode_t OP_CMPUI = 7'h0C;
	localparam opcode_t OP_FLT3 = 7'h0D;
	localparam opcode_t OP_MOV = 7'h0E;
	localparam opcode_t OP_NOP = 7'h7F;

	// Functions of the OP_R3 format
	localparam func_t FN_ADD = 7'h04;
	localparam func_t FN_SUB = 7'h05;
	localparam func_t FN_CMP = 7'h06;
	localparam func_t FN_CMPU = 7'h07;
	localparam func_t FN_AND = 7'h08;
	localparam func_t FN_OR = 7'h09;
	localparam func_t FN_EOR = 7'h0A;
	localparam func_t FN_NAND = 7'h0C;
	localparam func_t FN_NOR = 7'h0D;
	localparam func_t FN_ENOR = 7'h0E;
	localparam func_t FN_CMOVZ = 7'h10;
	localparam func_t FN_CMOVNZ = 7'h11;
	localparam func_t FN_MVVR = 7'h12;

	// Functions of the OP_FLT3 format
	localparam func_t FN_FLT1 = 7'h01;
	localparam func_t FN_FSEQ = 7'h08;
	localparam func_t FN_FSNE = 7'h09;
	localparam func_t FN_FSLT = 7'h0A;
	localparam func_t FN_FSLE = 7'h0B;
	localparam func_t FN_FCMP = 7'h0C;
	localparam func_t FN_SGNJ = 7'h10;
	localparam func_t FN_SGNJN = 7'h11;
	localparam func_t FN_SGNJX = 7'h12;

	// Sub-functions of FN_FLT1, single source operand
	localparam func_t FN_FTOI = 7'h02;
	localparam func_t FN_ITOF = 7'h03;
	localparam func_t FN_ISNAN = 7'h0E;
	localparam func_t FN_FINITE = 7'h0F;
	localparam func_t FN_FCVTH2S = 7'h10;
	localparam func_t FN_FTRUNC = 7'h15;
	localparam func_t FN_FABS = 7'h20;
	localparam func_t FN_FNEG = 7'h21;
	localparam func_t FN_FSIGN = 7'h26;

	// Counter value from which each registered result can be taken
	localparam cnt_t LAT_FTOI = 4'd1;
	localparam cnt_t LAT_ITOF = 4'd1;
	localparam cnt_t LAT_FTRUNC = 4'd1;

endpackage

`default_nettype wire

/* src.f */
qupls_pkg.sv
fp32_pkg.sv
change_det.sv
qupls_cmp.sv
f2i32.sv
i2f32.sv
fp_trunc32.sv
fp_cvt16to32.sv
qupls_fpu32.sv
tb_clock.sv
tb_qupls_fpu32.sv

/* tb_clock.sv */
`default_nettype none

module tb_clock (
	output logic clk
);

	// Half of the 4 unit clock period
	localparam int HALF = 2;

	initial begin
		clk = 1'b0;
		forever #HALF clk = ~clk;
	end

endmodule

`default_nettype wire

/* tb_qupls_fpu32.sv */
`default_nettype none

module tb_qupls_fpu32;
	import qupls_pkg::*;

	localparam int unsigned SEED = 32'h9166418b;
	localparam logic COMB = 1'b0;
	localparam logic REGD = 1'b1;

	// Compare words hold eq in bit 0, lt in bit 1, le in bit 2, unordered in bit 3 and gt in bit 4
	localparam word_t CMP_EQ = 32'h05;
	localparam word_t CMP_LT = 32'h06;
	localparam word_t CMP_GT = 32'h10;
	localparam word_t CMP_UN = 32'h08;

	logic clk;
	logic rst;
	instr_t ir;
	word_t a;
	word_t b;
	word_t c;
	word_t i;
	word_t o;
	logic done;
	logic tbl_ready;

	// Stimulus table with one slot per entry in every queue
	string tbl_name[$];
	instr_t tbl_ir[$];
	word_t tbl_a[$];
	word_t tbl_b[$];
	word_t tbl_c[$];
	word_t tbl_i[$];
	word_t tbl_exp[$];
	logic tbl_reg[$];

	tb_clock u_clk (
		.clk(clk)
	);

	qupls_fpu32 i_dut (
		.rst(rst),
		.clk(clk),
		.ir(ir),
		.a(a),
		.b(b),
		.c(c),
		.i(i),
		.o(o),
		.done(done)
	);

	// ========================================================================
	// Failure reporting and compare tasks
	// ========================================================================
	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp)
			stop_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_done(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_run($sformatf("ERROR %s done: expected %b, actual %b", name, exp, act));
	endtask

	// ========================================================================
	// Instruction encoders and the integer reference model
	// ========================================================================
	function automatic instr_t r3_instr(input func_t fn, input op4_t cmb);
		instr_t w;
		w = '0;
		w[FN_MSB:FN_LSB] = fn;
		w[OP4_MSB:OP4_LSB] = cmb;
		w[OPC_MSB:OPC_LSB] = OP_R3;
		return w;
	endfunction

	function automatic instr_t flt_instr(input func_t fn);
		instr_t w;
		w = '0;
		w[FN_MSB:FN_LSB] = fn;
		w[OPC_MSB:OPC_LSB] = OP_FLT3;
		return w;
	endfunction

	// Single source float ops hide behind FN_FLT1 with their own sub-function
	function automatic instr_t flt1_instr(input func_t sub);
		instr_t w;
		w = flt_instr(FN_FLT1);
		w[FN1_MSB:FN1_LSB] = sub;
		return w;
	endfunction

	function automatic instr_t imm_instr(input opcode_t op);
		instr_t w;
		w = '0;
		w[OPC_MSB:OPC_LSB] = op;
		return w;
	endfunction

	// Two operand function first and then c folded in by the combine code
	function automatic word_t r3_model(input func_t fn, input op4_t cmb, input word_t x,
		input word_t y, input word_t z);
		word_t first;
		word_t res;
		case (fn)
			FN_ADD: first = x + y;
			FN_SUB: first = x - y;
			FN_AND: first = x & y;
			FN_OR: first = x | y;
			FN_EOR: first = x ^ y;
			FN_NAND: first = ~(x & y);
			FN_NOR: first = ~(x | y);
			default: first = ~(x ^ y);
		endcase
		if (cmb == 3'd7 && fn == FN_OR)
			res = (x & y) | (y & z) | (x & z);
		else if (cmb == 3'd7)
			res = {31'd0, ^{x, y, z}};
		else if (cmb == 3'd0)
			res = first & z;
		else if (cmb == 3'd1)
			res = first | z;
		else if (cmb == 3'd2)
			res = first ^ z;
		else
			res = first + z;
		return res;
	endfunction

	task automatic add_entry(input string name, input instr_t ir_v, input word_t a_v,
		input word_t b_v, input word_t c_v, input word_t i_v, input word_t exp_v,
		input logic reg_v);
		tbl_name.push_back(name);
		tbl_ir.push_back(ir_v);
		tbl_a.push_back(a_v);
		tbl_b.push_back(b_v);
		tbl_c.push_back(c_v);
		tbl_i.push_back(i_v);
		tbl_exp.push_back(exp_v);
		tbl_reg.push_back(reg_v);
	endtask

	// ========================================================================
	// Table contents
	// ========================================================================
	task automatic build_table();
		func_t fns [8];
		word_t ra;
		word_t rb;
		word_t rc;
		word_t ri;
		fns = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_EOR, FN_NAND, FN_NOR, FN_ENOR};
		// Every first stage with each of the four combine codes
		for (int f = 0; f < 8; f++) begin
			for (int k = 0; k < 4; k++) begin
				ra = $urandom();
				rb = $urandom();
				rc = $urandom();
				add_entry($sformatf("r3 fn %02h cmb %0d", fns[f], k), r3_instr(fns[f], op4_t'(k)),
					ra, rb, rc, '0, r3_model(fns[f], op4_t'(k), ra, rb, rc), COMB);
			end
		end
		ra = $urandom();
		rb = $urandom();
		rc = $urandom();
		ri = $urandom();
		add_entry("majority", r3_instr(FN_OR, 3'd7), ra, rb, rc, '0,
			r3_model(FN_OR, 3'd7, ra, rb, rc), COMB);
		add_entry("parity", r3_instr(FN_EOR, 3'd7), ra, rb, rc, '0,
			r3_model(FN_EOR, 3'd7, ra, rb, rc), COMB);
		// A zero condition picks b for CMOVZ and c for CMOVNZ
		add_entry("cmovz zero", r3_instr(FN_CMOVZ, 3'd0), '0, rb, rc, '0, rb, COMB);
		add_entry("cmovz set", r3_instr(FN_CMOVZ, 3'd0), ra | 32'd1, rb, rc, '0, rc, COMB);
		add_entry("cmovnz zero", r3_instr(FN_CMOVNZ, 3'd0), '0, rb, rc, '0, rc, COMB);
		add_entry("cmovnz set", r3_instr(FN_CMOVNZ, 3'd0), ra | 32'd1, rb, rc, '0, rb, COMB);
		add_entry("addi", imm_instr(OP_ADDI), ra, '0, '0, ri, ra + ri, COMB);
		add_entry("andi", imm_instr(OP_ANDI), ra, '0, '0, ri, ra & ri, COMB);
		add_entry("ori", imm_instr(OP_ORI), ra, '0, '0, ri, ra | ri, COMB);
		add_entry("eori", imm_instr(OP_EORI), ra, '0, '0, ri, ra ^ ri, COMB);
		add_entry("mov", imm_instr(OP_MOV), rb, '0, '0, '0, rb, COMB);

		// Integer compares put signed against unsigned on the same negative value
		add_entry("cmp neg", r3_instr(FN_CMP, 3'd0), 32'hFFFF_FFFB, 32'd3, '0, '0, CMP_LT, COMB);
		add_entry("cmpu neg", r3_instr(FN_CMPU, 3'd0), 32'hFFFF_FFFB, 32'd3, '0, '0, CMP_GT, COMB);
		add_entry("cmp eq", r3_instr(FN_CMP, 3'd0), 32'd7, 32'd7, '0, '0, CMP_EQ, COMB);
		add_entry("cmp min", r3_instr(FN_CMP, 3'd0), 32'h8000_0000, 32'h7FFF_FFFF, '0, '0,
			CMP_LT, COMB);
		add_entry("cmpi eq", imm_instr(OP_CMPI), 32'hFFFF_FFFF, '0, '0, 32'hFFFF_FFFF, CMP_EQ, COMB);
		add_entry("cmpi gt", imm_instr(OP_CMPI), 32'd10, '0, '0, 32'hFFFF_FFEC, CMP_GT, COMB);
		add_entry("cmpui lt", imm_instr(OP_CMPUI), 32'd10, '0, '0, 32'hFFFF_FFEC, CMP_LT, COMB);

		// Classification and sign handling
		add_entry("fabs", flt1_instr(FN_FABS), 32'hC020_0000, '0, '0, '0, 32'h4020_0000, COMB);
		add_entry("fneg one", flt1_instr(FN_FNEG), 32'h3F80_0000, '0, '0, '0, 32'hBF80_0000, COMB);
		add_entry("fneg zero", flt1_instr(FN_FNEG), '0, 32'd1, '0, '0, 32'h8000_0000, COMB);
		add_entry("fsign neg", flt1_instr(FN_FSIGN), 32'hC020_0000, '0, '0, '0, 32'hBF80_0000, COMB);
		add_entry("fsign inf", flt1_instr(FN_FSIGN), 32'h7F80_0000, '0, '0, '0, 32'h3F80_0000, COMB);
		add_entry("fsign nzero", flt1_instr(FN_FSIGN), 32'h8000_0000, '0, '0, '0, 32'h8000_0000,
			COMB);
		add_entry("fsign nan", flt1_instr(FN_FSIGN), 32'hFF80_0001, '0, '0, '0, 32'h7FC0_0000, COMB);
		add_entry("isnan nan", flt1_instr(FN_ISNAN), 32'h7FC0_0000, '0, '0, '0, 32'd1, COMB);
		add_entry("isnan inf", flt1_instr(FN_ISNAN), 32'h7F80_0000, '0, '0, '0, 32'd0, COMB);
		add_entry("finite inf", flt1_instr(FN_FINITE), 32'hFF80_0000, '0, '0, '0, 32'd0, COMB);
		add_entry("finite num", flt1_instr(FN_FINITE), 32'h4020_0000, '0, '0, '0, 32'd1, COMB);
		add_entry("finite nan", flt1_instr(FN_FINITE), 32'h7FC0_0000, '0, '0, '0, 32'd0, COMB);
		add_entry("sgnj", flt_instr(FN_SGNJ), 32'hBF80_0000, 32'h4020_0000, '0, '0, 32'hC020_0000,
			COMB);
		add_entry("sgnjn", flt_instr(FN_SGNJN), 32'hBF80_0000, 32'h4020_0000, '0, '0, 32'h4020_0000,
			COMB);
		add_entry("sgnjx", flt_instr(FN_SGNJX), 32'hBF80_0000, 32'hC020_0000, '0, '0, 32'h4020_0000,
			COMB);

		// A NaN on either side of a float compare leaves the pair unordered
		add_entry("fseq zeros", flt_instr(FN_FSEQ), 32'h8000_0000, '0, '0, '0, 32'd1, COMB);
		add_entry("fsne", flt_instr(FN_FSNE), 32'h3F80_0000, 32'h4020_0000, '0, '0, 32'd1, COMB);
		add_entry("fslt", flt_instr(FN_FSLT), 32'hC020_0000, 32'h3F80_0000, '0, '0, 32'd1, COMB);
		add_entry("fsle", flt_instr(FN_FSLE), 32'h4020_0000, 32'h3F80_0000, '0, '0, 32'd0, COMB);
		add_entry("fslt nan", flt_instr(FN_FSLT), 32'h7FC0_0000, 32'h3F80_0000, '0, '0, 32'd0, COMB);
		add_entry("fsne nan", flt_instr(FN_FSNE), 32'h7FC0_0000, 32'h7FC0_0000, '0, '0, 32'd1, COMB);
		add_entry("fcmp nan", flt_instr(FN_FCMP), 32'h3F80_0000, 32'h7FC0_0000, '0, '0, CMP_UN, COMB);
		add_entry("fcmp neg", flt_instr(FN_FCMP), 32'hC020_0000, 32'hBF80_0000, '0, '0, CMP_LT, COMB);
		add_entry("fcmp inf", flt_instr(FN_FCMP), 32'h7F80_0000, 32'h4020_0000, '0, '0, CMP_GT, COMB);
		add_entry("fcmp zeros", flt_instr(FN_FCMP), 32'h8000_0000, '0, '0, '0, CMP_EQ, COMB);

		// Every registered conversion has an a that differs from the entry before it
		add_entry("ftoi pos", flt1_instr(FN_FTOI), 32'h4020_0000, '0, '0, '0, 32'd2, REGD);
		add_entry("ftoi neg", flt1_instr(FN_FTOI), 32'hC020_0000, '0, '0, '0, 32'hFFFF_FFFE, REGD);
		add_entry("ftoi small", flt1_instr(FN_FTOI), 32'h3F40_0000, '0, '0, '0, 32'd0, REGD);
		add_entry("ftoi big", flt1_instr(FN_FTOI), 32'h4F32_D05E, '0, '0, '0, 32'h7FFF_FFFF, REGD);
		add_entry("ftoi ninf", flt1_instr(FN_FTOI), 32'hFF80_0000, '0, '0, '0, 32'h8000_0000, REGD);
		add_entry("ftoi nan", flt1_instr(FN_FTOI), 32'h7FC0_0000, '0, '0, '0, 32'h7FFF_FFFF, REGD);
		add_entry("itof five", flt1_instr(FN_ITOF), 32'd5, '0, '0, '0, 32'h40A0_0000, REGD);
		add_entry("itof neg", flt1_instr(FN_ITOF), 32'hFFFF_FFFF, '0, '0, '0, 32'hBF80_0000, REGD);
		add_entry("itof zero", flt1_instr(FN_ITOF), '0, 32'd9, '0, '0, 32'd0, REGD);
		// Two halfway cases where one rounds down to even and one rounds up to even
		add_entry("itof tie dn", flt1_instr(FN_ITOF), 32'h0100_0001, '0, '0, '0, 32'h4B80_0000, REGD);
		add_entry("itof tie up", flt1_instr(FN_ITOF), 32'h0100_0003, '0, '0, '0, 32'h4B80_0002, REGD);
		add_entry("ftrunc pos", flt1_instr(FN_FTRUNC), 32'h4020_0000, '0, '0, '0, 32'h4000_0000,
			REGD);
		add_entry("ftrunc neg", flt1_instr(FN_FTRUNC), 32'hBFC0_0000, '0, '0, '0, 32'hBF80_0000,
			REGD);
		add_entry("ftrunc frac", flt1_instr(FN_FTRUNC), 32'hBF40_0000, '0, '0, '0, 32'h8000_0000,
			REGD);
		add_entry("ftrunc inf", flt1_instr(FN_FTRUNC), 32'h7F80_0000, '0, '0, '0, 32'h7F80_0000,
			REGD);

		// Half to single conversion takes its source from the low half of a
		add_entry("h2s one", flt1_instr(FN_FCVTH2S), 32'h3C00, '0, '0, '0, 32'h3F80_0000, COMB);
		add_entry("h2s neg", flt1_instr(FN_FCVTH2S), 32'hC100, '0, '0, '0, 32'hC020_0000, COMB);
		add_entry("h2s sub min", flt1_instr(FN_FCVTH2S), 32'h0001, '0, '0, '0, 32'h3380_0000, COMB);
		add_entry("h2s sub", flt1_instr(FN_FCVTH2S), 32'h0300, '0, '0, '0, 32'h3840_0000, COMB);
		add_entry("h2s inf", flt1_instr(FN_FCVTH2S), 32'hFC00, '0, '0, '0, 32'hFF80_0000, COMB);
		add_entry("h2s nan", flt1_instr(FN_FCVTH2S), 32'h7E00, '0, '0, '0, 32'h7FC0_0000, COMB);
	endtask

	// ========================================================================
	// Run the table
	// ========================================================================
	initial begin
		rst = 1'b1;
		ir = '0;
		a = '0;
		b = '0;
		c = '0;
		i = '0;
		tbl_ready = 1'b0;
		void'($urandom(SEED));
		build_table();
		tbl_ready = 1'b1;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int n = 0; n < tbl_name.size(); n++) begin
			@(posedge clk);
			#1;
			ir = tbl_ir[n];
			a = tbl_a[n];
			b = tbl_b[n];
			c = tbl_c[n];
			i = tbl_i[n];
			#2;
			// New operands hold done low and the result lands two edges later
			if (tbl_reg[n]) begin
				check_done({tbl_name[n], " start"}, 1'b0, done);
				repeat (2) @(posedge clk);
				#3;
			end
			check_done(tbl_name[n], 1'b1, done);
			check_word(tbl_name[n], tbl_exp[n], o);
		end
		$display("Done: no errors");
		$finish;
	end

	// Ten cycles per table entry is far more than any entry needs
	initial begin
		wait (tbl_ready);
		repeat (tbl_name.size() * 10) @(posedge clk);
		stop_run("Timeout: the table did not finish in time");
	end

endmodule

`default_nettype wire
